// File: source/llc_defines.svh
`ifndef LLC_DEFINES_SVH
`define LLC_DEFINES_SVH

// cache geometry.
`define LLC_WAYS 4
`define LLC_SETS 16
`define LLC_SET_BITS 4

// line address is tag then set index.
`define LLC_TAG_BITS 8
`define LLC_ADDR_BITS 12

// one line is a single 32-bit word.
`define LLC_LINE_BITS 32

`endif

// File: source/llc_pkg.sv
`include "llc_defines.svh"

package llc_pkg;

    typedef logic [`LLC_ADDR_BITS-1:0] llc_addr_t;
    typedef logic [`LLC_TAG_BITS-1:0]  llc_tag_t;
    typedef logic [`LLC_SET_BITS-1:0]  llc_set_t;
    typedef logic [`LLC_LINE_BITS-1:0] llc_line_t;
    typedef logic [$clog2(`LLC_WAYS)-1:0] llc_way_t;

    typedef enum logic [1:0] {INVALID = 2'b00, VALID = 2'b01, DIRTY = 2'b10} llc_state_e;
    typedef enum logic {OP_READ = 1'b0, OP_WRITE = 1'b1} llc_op_e;
    // gray order, as the loop only ever steps to its neighbour.
    typedef enum logic [1:0] {DECODE = 2'b00, READ = 2'b01, PROCESS = 2'b11, UPDATE = 2'b10} llc_ctrl_e;

    typedef struct packed {
        llc_op_e   op;
        llc_addr_t addr;
        llc_line_t data;
    } llc_req_t;

    typedef struct packed {
        llc_addr_t addr;
        llc_line_t data;
        logic      hit;
    } llc_rsp_t;

    typedef struct packed {
        logic      write;
        llc_addr_t addr;
        llc_line_t data;
    } llc_mem_req_t;

    typedef struct packed {
        llc_line_t data;
    } llc_mem_rsp_t;

    typedef struct packed {
        llc_tag_t   tag;
        llc_state_e state;
        llc_line_t  line;
    } llc_way_data_t;

endpackage

// File: source/llc_input_decoder.sv
`timescale 1ns/1ns

module llc_input_decoder import llc_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  llc_req_t req_in_i,
    input  logic     req_in_valid_i,
    output logic     req_in_ready_o,
    input  logic     rst_tb_i,
    input  logic     rst_tb_valid_i,
    output logic     rst_tb_ready_o,
    input  logic     decode_en_i,
    input  logic     rst_stall_i,
    output llc_req_t msg_req_o,
    output logic     msg_is_req_o,
    output logic     msg_is_flush_o
);

    llc_req_t req_q;
    logic     req_full;
    logic     flush_full;
    logic     flush_cmd;
    logic     take_req;
    logic     take_flush;

    // requests are held off until the first flush completes.
    assign req_in_ready_o = !req_full && !rst_stall_i;
    assign rst_tb_ready_o = !flush_full;

    assign take_flush = decode_en_i && flush_full; // flush has priority.
    assign take_req   = decode_en_i && req_full && !flush_full && !rst_stall_i;

    assign msg_is_flush_o = take_flush && flush_cmd;
    assign msg_is_req_o   = take_req;
    assign msg_req_o      = req_q;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            req_full <= 1'b0;
        end else if (req_in_valid_i && req_in_ready_o) begin
            req_full <= 1'b1;
        end else if (take_req) begin
            req_full <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            flush_full <= 1'b0;
        end else if (rst_tb_valid_i && rst_tb_ready_o) begin
            flush_full <= 1'b1;
        end else if (take_flush) begin
            flush_full <= 1'b0; // a zero command is dropped here.
        end
    end

    always_ff @(posedge clk) begin
        if (req_in_valid_i && req_in_ready_o) begin
            req_q <= req_in_i;
        end
        if (rst_tb_valid_i && rst_tb_ready_o) begin
            flush_cmd <= rst_tb_i;
        end
    end

endmodule

// File: source/llc_localmem.sv
`timescale 1ns/1ns
`include "llc_defines.svh"

module llc_localmem import llc_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  llc_set_t      rd_set_i,
    output llc_way_data_t rd_ways_o [`LLC_WAYS],
    output llc_way_t      rd_evict_way_o,
    input  logic          wr_en_i,
    input  llc_set_t      wr_set_i,
    input  llc_way_t      wr_way_i,
    input  llc_way_data_t wr_data_i,
    input  logic          wr_evict_en_i,
    input  llc_way_t      wr_evict_way_i,
    input  logic          wr_all_invalid_i
);

    llc_tag_t   tag_mem   [`LLC_SETS][`LLC_WAYS];
    llc_line_t  line_mem  [`LLC_SETS][`LLC_WAYS];
    llc_state_e state_mem [`LLC_SETS][`LLC_WAYS]; // INVALID or VALID.
    logic       dirty_mem [`LLC_SETS][`LLC_WAYS];
    llc_way_t   evict_mem [`LLC_SETS];

    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            tag_mem[wr_set_i][wr_way_i]  <= wr_data_i.tag;
            line_mem[wr_set_i][wr_way_i] <= wr_data_i.line;
        end
    end

    // DIRTY is kept as a valid line plus its dirty bit.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            for (int s = 0; s < `LLC_SETS; s++) begin
                for (int w = 0; w < `LLC_WAYS; w++) begin
                    state_mem[s][w] <= INVALID;
                    dirty_mem[s][w] <= 1'b0;
                end
                evict_mem[s] <= '0;
            end
        end else if (wr_all_invalid_i) begin
            for (int w = 0; w < `LLC_WAYS; w++) begin
                state_mem[wr_set_i][w] <= INVALID;
                dirty_mem[wr_set_i][w] <= 1'b0; // dirty data is lost.
            end
            evict_mem[wr_set_i] <= '0;
        end else begin
            if (wr_en_i) begin
                state_mem[wr_set_i][wr_way_i] <= (wr_data_i.state == INVALID) ? INVALID : VALID;
                dirty_mem[wr_set_i][wr_way_i] <= (wr_data_i.state == DIRTY);
            end
            if (wr_evict_en_i) begin
                evict_mem[wr_set_i] <= wr_evict_way_i;
            end
        end
    end

    // whole set comes out one cycle after the index.
    always_ff @(posedge clk) begin
        for (int w = 0; w < `LLC_WAYS; w++) begin
            rd_ways_o[w].tag   <= tag_mem[rd_set_i][w];
            rd_ways_o[w].line  <= line_mem[rd_set_i][w];
            rd_ways_o[w].state <= dirty_mem[rd_set_i][w] ? DIRTY : state_mem[rd_set_i][w];
        end
        rd_evict_way_o <= evict_mem[rd_set_i];
    end

endmodule

// File: source/llc_process_request.sv
`timescale 1ns/1ns
`include "llc_defines.svh"

module llc_process_request import llc_pkg::*; (
    input  logic          clk,
    input  logic          rst,
    input  logic          start_i,
    input  llc_req_t      req_i,
    input  llc_way_data_t ways_i [`LLC_WAYS],
    input  llc_way_t      evict_way_i,
    output llc_rsp_t      rsp_out_o,
    output logic          rsp_out_valid_o,
    input  logic          rsp_out_ready_i,
    output llc_mem_req_t  mem_req_o,
    output logic          mem_req_valid_o,
    input  logic          mem_req_ready_i,
    input  llc_mem_rsp_t  mem_rsp_i,
    input  logic          mem_rsp_valid_i,
    output logic          mem_rsp_ready_o,
    output logic          done_o,
    output llc_way_t      upd_way_o,
    output llc_way_data_t upd_data_o,
    output llc_way_t      upd_evict_o
);

    typedef enum logic [2:0] {P_LOOK, P_WB, P_FILL_REQ, P_FILL_RSP, P_RSP} phase_e;

    phase_e        phase;
    phase_e        next_phase;
    llc_tag_t      req_tag;
    llc_set_t      req_set;
    logic          hit;
    llc_way_t      hit_way;
    logic          found_inv;
    llc_way_t      victim;
    llc_way_data_t victim_data;
    llc_line_t     fill_line;
    llc_line_t     new_line;
    llc_state_e    new_state;

    assign req_tag     = req_i.addr[`LLC_ADDR_BITS-1:`LLC_SET_BITS];
    assign req_set     = req_i.addr[`LLC_SET_BITS-1:0];
    assign victim_data = ways_i[victim];

    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = 0; w < `LLC_WAYS; w++) begin
            if (ways_i[w].state != INVALID && ways_i[w].tag == req_tag) begin
                hit     = 1'b1;
                hit_way = llc_way_t'(w);
            end
        end
    end

    // first free way, else the round-robin pointer.
    always_comb begin
        found_inv = 1'b0;
        victim    = evict_way_i;
        for (int w = 0; w < `LLC_WAYS; w++) begin
            if (!found_inv && ways_i[w].state == INVALID) begin
                found_inv = 1'b1;
                victim    = llc_way_t'(w);
            end
        end
    end

    always_comb begin
        next_phase = phase;
        case (phase)
            P_LOOK: begin
                if (start_i && !hit) begin
                    next_phase = (victim_data.state == DIRTY) ? P_WB : P_FILL_REQ;
                end
            end
            P_WB:       if (mem_req_ready_i) next_phase = P_FILL_REQ;
            P_FILL_REQ: if (mem_req_ready_i) next_phase = P_FILL_RSP;
            P_FILL_RSP: if (mem_rsp_valid_i) next_phase = P_RSP;
            P_RSP:      if (rsp_out_ready_i) next_phase = P_LOOK;
            default:    next_phase = P_LOOK;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            phase <= P_LOOK;
        end else begin
            phase <= next_phase;
        end
    end

    always_ff @(posedge clk) begin
        if (phase == P_FILL_RSP && mem_rsp_valid_i) begin
            fill_line <= mem_rsp_i.data;
        end
    end

    // a write replaces the whole line.
    always_comb begin
        if (req_i.op == OP_WRITE) begin
            new_line  = req_i.data;
            new_state = DIRTY;
        end else if (hit) begin
            new_line  = ways_i[hit_way].line;
            new_state = ways_i[hit_way].state;
        end else begin
            new_line  = fill_line;
            new_state = VALID;
        end
    end

    always_comb begin
        if (phase == P_WB) begin
            mem_req_o = '{write: 1'b1, addr: {victim_data.tag, req_set}, data: victim_data.line};
        end else begin
            mem_req_o = '{write: 1'b0, addr: req_i.addr, data: '0};
        end
    end

    assign mem_req_valid_o = (phase == P_WB) || (phase == P_FILL_REQ);
    assign mem_rsp_ready_o = (phase == P_FILL_RSP);

    assign rsp_out_o       = '{addr: req_i.addr, data: new_line, hit: hit};
    assign rsp_out_valid_o = (start_i && phase == P_LOOK && hit) || (phase == P_RSP);
    assign done_o          = rsp_out_valid_o && rsp_out_ready_i;

    assign upd_way_o   = hit ? hit_way : victim;
    assign upd_data_o  = '{tag: req_tag, state: new_state, line: new_line};
    assign upd_evict_o = hit ? evict_way_i : victim + llc_way_t'(1); // wraps at 4.

endmodule

// File: source/llc.sv
`timescale 1ns/1ns
`include "llc_defines.svh"

module llc import llc_pkg::*; (
    input  logic         clk,
    input  logic         rst,
    input  llc_req_t     req_in_i,
    input  logic         req_in_valid_i,
    output logic         req_in_ready_o,
    input  logic         rst_tb_i,
    input  logic         rst_tb_valid_i,
    output logic         rst_tb_ready_o,
    output llc_rsp_t     rsp_out_o,
    output logic         rsp_out_valid_o,
    input  logic         rsp_out_ready_i,
    output llc_mem_req_t mem_req_o,
    output logic         mem_req_valid_o,
    input  logic         mem_req_ready_i,
    input  llc_mem_rsp_t mem_rsp_i,
    input  logic         mem_rsp_valid_i,
    output logic         mem_rsp_ready_o,
    output logic         rst_tb_done_o,
    output logic         rst_tb_done_valid_o,
    input  logic         rst_tb_done_ready_i
);

    llc_ctrl_e     state;
    llc_ctrl_e     next_state;
    logic          decode_en;
    logic          rd_en;
    logic          process_en;
    logic          update_en;

    llc_req_t      msg_req;
    logic          msg_is_req;
    logic          msg_is_flush;
    logic          rst_stall;

    llc_req_t      cur_req;
    logic          cur_flush;
    llc_set_t      cur_set;

    llc_way_data_t rd_ways [`LLC_WAYS];
    llc_way_t      rd_evict_way;
    llc_way_data_t ways_buf [`LLC_WAYS];
    llc_way_t      evict_buf;

    logic          proc_done;
    llc_way_t      upd_way;
    llc_way_t      upd_way_q;
    llc_way_data_t upd_data;
    llc_way_t      upd_evict;

    llc_set_t      flush_set;
    logic          process_done;
    logic          done_xfer;
    logic          wr_en;

    assign decode_en  = (state == DECODE);
    assign rd_en      = (state == READ);
    assign process_en = (state == PROCESS);
    assign update_en  = (state == UPDATE);

    assign cur_set      = cur_req.addr[`LLC_SET_BITS-1:0];
    assign process_done = cur_flush ? (flush_set == llc_set_t'(`LLC_SETS - 1)) : proc_done;
    assign done_xfer    = rst_tb_done_valid_o && rst_tb_done_ready_i;
    assign wr_en        = update_en && !cur_flush;

    always_comb begin
        next_state = state;
        case (state)
            DECODE:  if (msg_is_req || msg_is_flush) next_state = READ;
            READ:    next_state = PROCESS;
            PROCESS: if (process_done) next_state = UPDATE;
            UPDATE:  if (!cur_flush || done_xfer) next_state = DECODE;
            default: next_state = DECODE;
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= DECODE;
        end else begin
            state <= next_state;
        end
    end

    llc_input_decoder decoder_i (
        .clk            (clk),
        .rst            (rst),
        .req_in_i       (req_in_i),
        .req_in_valid_i (req_in_valid_i),
        .req_in_ready_o (req_in_ready_o),
        .rst_tb_i       (rst_tb_i),
        .rst_tb_valid_i (rst_tb_valid_i),
        .rst_tb_ready_o (rst_tb_ready_o),
        .decode_en_i    (decode_en),
        .rst_stall_i    (rst_stall),
        .msg_req_o      (msg_req),
        .msg_is_req_o   (msg_is_req),
        .msg_is_flush_o (msg_is_flush)
    );

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            cur_flush <= 1'b0;
        end else if (msg_is_req || msg_is_flush) begin
            cur_flush <= msg_is_flush;
        end
    end

    always_ff @(posedge clk) begin
        if (msg_is_req) begin
            cur_req <= msg_req;
        end
    end

    // stalled from reset until a flush has been answered.
    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            rst_stall <= 1'b1;
        end else if (msg_is_flush) begin
            rst_stall <= 1'b1;
        end else if (done_xfer) begin
            rst_stall <= 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            flush_set <= '0;
        end else if (process_en && cur_flush) begin
            flush_set <= flush_set + llc_set_t'(1); // back to 0 after the last set.
        end
    end

    llc_localmem localmem_i (
        .clk              (clk),
        .rst              (rst),
        .rd_set_i         (msg_req.addr[`LLC_SET_BITS-1:0]),
        .rd_ways_o        (rd_ways),
        .rd_evict_way_o   (rd_evict_way),
        .wr_en_i          (wr_en),
        .wr_set_i         (cur_flush ? flush_set : cur_set),
        .wr_way_i         (upd_way_q),
        .wr_data_i        (ways_buf[upd_way_q]),
        .wr_evict_en_i    (wr_en),
        .wr_evict_way_i   (evict_buf),
        .wr_all_invalid_i (process_en && cur_flush)
    );

    // buffers take the set in READ and the result when PROCESS ends.
    always_ff @(posedge clk) begin
        if (rd_en) begin
            ways_buf  <= rd_ways;
            evict_buf <= rd_evict_way;
        end else if (proc_done) begin
            ways_buf[upd_way] <= upd_data;
            evict_buf         <= upd_evict;
            upd_way_q         <= upd_way;
        end
    end

    llc_process_request process_i (
        .clk             (clk),
        .rst             (rst),
        .start_i         (process_en && !cur_flush),
        .req_i           (cur_req),
        .ways_i          (ways_buf),
        .evict_way_i     (evict_buf),
        .rsp_out_o       (rsp_out_o),
        .rsp_out_valid_o (rsp_out_valid_o),
        .rsp_out_ready_i (rsp_out_ready_i),
        .mem_req_o       (mem_req_o),
        .mem_req_valid_o (mem_req_valid_o),
        .mem_req_ready_i (mem_req_ready_i),
        .mem_rsp_i       (mem_rsp_i),
        .mem_rsp_valid_i (mem_rsp_valid_i),
        .mem_rsp_ready_o (mem_rsp_ready_o),
        .done_o          (proc_done),
        .upd_way_o       (upd_way),
        .upd_data_o      (upd_data),
        .upd_evict_o     (upd_evict)
    );

    assign rst_tb_done_o       = 1'b1;
    assign rst_tb_done_valid_o = update_en && cur_flush; // held in UPDATE until taken.

endmodule

// File: verification/llc_properties.sv
`timescale 1ns/1ns

module llc_properties import llc_pkg::*; (
    input logic         clk,
    input logic         rst,
    input logic         req_in_ready_i,
    input llc_rsp_t     rsp_out_i,
    input logic         rsp_out_valid_i,
    input logic         rsp_out_ready_i,
    input llc_mem_req_t mem_req_i,
    input logic         mem_req_valid_i,
    input logic         mem_req_ready_i,
    input logic         rst_tb_done_i,
    input logic         rst_tb_done_valid_i,
    input logic         rst_tb_done_ready_i
);

    int   fail_count = 0;
    logic flush_seen;

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            flush_seen <= 1'b0;
        end else if (rst_tb_done_valid_i && rst_tb_done_ready_i) begin
            flush_seen <= 1'b1; // first rst_tb_done transfer.
        end
    end

    // requests stay blocked until the first flush is answered.
    a_blocked: assert property (@(posedge clk) disable iff (!rst)
        !flush_seen |-> !req_in_ready_i)
        else begin
            fail_count++;
            $error("req_in ready rose before the first rst_tb_done transfer");
        end

    a_rsp_hold: assert property (@(posedge clk) disable iff (!rst)
        rsp_out_valid_i && !rsp_out_ready_i |=> rsp_out_valid_i && $stable(rsp_out_i))
        else begin
            fail_count++;
            $error("rsp_out changed or dropped before its transfer");
        end

    a_mem_req_hold: assert property (@(posedge clk) disable iff (!rst)
        mem_req_valid_i && !mem_req_ready_i |=> mem_req_valid_i && $stable(mem_req_i))
        else begin
            fail_count++;
            $error("mem_req changed or dropped before its transfer");
        end

    a_done_hold: assert property (@(posedge clk) disable iff (!rst)
        rst_tb_done_valid_i && !rst_tb_done_ready_i |=> rst_tb_done_valid_i && rst_tb_done_i)
        else begin
            fail_count++;
            $error("rst_tb_done dropped before its transfer");
        end

endmodule

bind llc llc_properties props_i (
    .clk                 (clk),
    .rst                 (rst),
    .req_in_ready_i      (req_in_ready_o),
    .rsp_out_i           (rsp_out_o),
    .rsp_out_valid_i     (rsp_out_valid_o),
    .rsp_out_ready_i     (rsp_out_ready_i),
    .mem_req_i           (mem_req_o),
    .mem_req_valid_i     (mem_req_valid_o),
    .mem_req_ready_i     (mem_req_ready_i),
    .rst_tb_done_i       (rst_tb_done_o),
    .rst_tb_done_valid_i (rst_tb_done_valid_o),
    .rst_tb_done_ready_i (rst_tb_done_ready_i)
);

// File: verification/llc_tb.sv
`timescale 1ns/1ns
`include "llc_defines.svh"

module llc_tb
    import llc_pkg::*;
();

    localparam int SEED              = 77060;
    localparam int ADDR_COUNT        = 1 << `LLC_ADDR_BITS;
    localparam int ACCESS_COUNT      = 100;
    localparam int CYCLES_PER_ACCESS = 50;
    localparam int TIMEOUT_CYCLES    = ACCESS_COUNT * CYCLES_PER_ACCESS
                                       + 2 * (`LLC_SETS + 24) + 50;

    logic         clk = 1'b0;
    logic         rst = 1'b0;
    llc_req_t     req_in = '0;
    logic         req_valid = 1'b0;
    logic         req_ready;
    logic         rst_tb_cmd = 1'b0;
    logic         rst_tb_valid = 1'b0;
    logic         rst_tb_ready;
    llc_rsp_t     rsp_out;
    logic         rsp_valid;
    logic         rsp_ready = 1'b0;
    llc_mem_req_t mem_req;
    logic         mem_req_valid;
    logic         mem_req_ready = 1'b0;
    llc_mem_rsp_t mem_rsp = '0;
    logic         mem_rsp_valid = 1'b0;
    logic         mem_rsp_ready;
    logic         done_flag;
    logic         done_valid;
    logic         done_ready = 1'b0;

    llc_line_t mem_model [ADDR_COUNT];
    llc_line_t shadow [ADDR_COUNT];   // last write since the latest flush.
    logic      shadow_valid [ADDR_COUNT];
    logic      fill_pending = 1'b0;
    llc_addr_t fill_addr = '0;
    int        fill_wait = 0;
    int        cycle_count = 0;

    always #2 clk = ~clk;

    llc dut_i (
        .clk                 (clk),
        .rst                 (rst),
        .req_in_i            (req_in),
        .req_in_valid_i      (req_valid),
        .req_in_ready_o      (req_ready),
        .rst_tb_i            (rst_tb_cmd),
        .rst_tb_valid_i      (rst_tb_valid),
        .rst_tb_ready_o      (rst_tb_ready),
        .rsp_out_o           (rsp_out),
        .rsp_out_valid_o     (rsp_valid),
        .rsp_out_ready_i     (rsp_ready),
        .mem_req_o           (mem_req),
        .mem_req_valid_o     (mem_req_valid),
        .mem_req_ready_i     (mem_req_ready),
        .mem_rsp_i           (mem_rsp),
        .mem_rsp_valid_i     (mem_rsp_valid),
        .mem_rsp_ready_o     (mem_rsp_ready),
        .rst_tb_done_o       (done_flag),
        .rst_tb_done_valid_o (done_valid),
        .rst_tb_done_ready_i (done_ready)
    );

    // every address bit shows up in the line.
    function automatic llc_line_t init_value(llc_addr_t addr);
        return {addr, ~addr, addr[7:0] ^ 8'h5a};
    endfunction

    task automatic stop_with_failure();
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic compare_value(input string test, input string what,
                                 input logic [31:0] expected, input logic [31:0] actual);
        assert (actual == expected) else begin
            $display("Error: %s %s expected %h actual %h", test, what, expected, actual);
            stop_with_failure();
        end
    endtask

    task automatic start_req(input llc_op_e op, input llc_addr_t addr, input llc_line_t data);
        @(posedge clk);
        req_in    <= '{op: op, addr: addr, data: data};
        req_valid <= 1'b1;
    endtask

    task automatic finish_req();
        do @(negedge clk); while (!req_ready);
        @(posedge clk); // transfer edge.
        req_valid <= 1'b0;
    endtask

    // hit_mode 0 expects a miss, 1 a hit, other values skip the flag.
    task automatic check_rsp(input string test, input llc_op_e op, input llc_addr_t addr,
                             input llc_line_t data, input int hit_mode, output logic hit);
        llc_rsp_t  rsp;
        llc_line_t expected;
        do @(negedge clk); while (!(rsp_valid && rsp_ready));
        rsp      = rsp_out;
        expected = shadow_valid[addr] ? shadow[addr] : mem_model[addr];
        @(posedge clk);
        compare_value(test, "address", 32'(addr), 32'(rsp.addr));
        if (hit_mode == 0 || hit_mode == 1) begin
            compare_value(test, "hit flag", hit_mode, 32'(rsp.hit));
        end
        if (op == OP_WRITE) begin
            shadow[addr]       = data;
            shadow_valid[addr] = 1'b1;
        end else begin
            compare_value(test, "read data", expected, rsp.data);
        end
        hit = rsp.hit;
    endtask

    task automatic access(input string test, input llc_op_e op, input llc_addr_t addr,
                          input llc_line_t data, input int hit_mode, output logic hit);
        start_req(op, addr, data);
        finish_req();
        check_rsp(test, op, addr, data, hit_mode, hit);
    endtask

    task automatic run_flush(input string test);
        int wait_cycles;
        @(posedge clk);
        rst_tb_cmd   <= 1'b1;
        rst_tb_valid <= 1'b1;
        do @(negedge clk); while (!rst_tb_ready);
        @(posedge clk);
        rst_tb_valid <= 1'b0;
        wait_cycles = 0;
        do begin
            @(negedge clk);
            wait_cycles++;
        end while (!done_valid);
        assert (wait_cycles >= `LLC_SETS) else begin
            $display("Error: %s sweep cycles expected at least %0d actual %0d",
                     test, `LLC_SETS, wait_cycles);
            stop_with_failure();
        end
        while (!done_ready) @(negedge clk);
        compare_value(test, "done payload", 1, 32'(done_flag));
        @(posedge clk);
        for (int a = 0; a < ADDR_COUNT; a++) begin
            shadow_valid[a] = 1'b0; // cache content is gone.
        end
    endtask

    initial begin
        for (int a = 0; a < ADDR_COUNT; a++) begin
            mem_model[a]    = init_value(llc_addr_t'(a));
            shadow[a]       = '0;
            shadow_valid[a] = 1'b0;
        end
    end

    // memory: random ready, fill data 0 to 3 cycles after the request.
    always @(posedge clk) begin
        mem_req_ready <= ($urandom_range(3) != 0);
        if (mem_req_valid && mem_req_ready) begin
            if (mem_req.write) begin
                mem_model[mem_req.addr] <= mem_req.data;
            end else begin
                fill_pending <= 1'b1;
                fill_addr    <= mem_req.addr;
                fill_wait    <= $urandom_range(3);
            end
        end
        if (mem_rsp_valid && mem_rsp_ready) begin
            mem_rsp_valid <= 1'b0;
        end else if (fill_pending && !mem_rsp_valid) begin
            if (fill_wait == 0) begin
                mem_rsp_valid <= 1'b1;
                mem_rsp       <= '{data: mem_model[fill_addr]};
                fill_pending  <= 1'b0;
            end else begin
                fill_wait <= fill_wait - 1;
            end
        end
    end

    always @(posedge clk) begin
        rsp_ready  <= ($urandom_range(3) != 0); // back-pressure on responses.
        done_ready <= ($urandom_range(1) != 0);
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Error: timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            stop_with_failure();
        end
    end

    always @(negedge clk) begin
        if (dut_i.props_i.fail_count != 0) begin
            $display("Error: a handshake property on the DUT ports failed");
            stop_with_failure();
        end
    end

    initial begin
        llc_addr_t rand_addr;
        llc_addr_t dirty_addr;
        llc_line_t data;
        llc_line_t mem_before;
        logic      hit;
        int        misses;

        void'($urandom(SEED));
        repeat (4) @(posedge clk);
        rst <= 1'b1;

        // a read raised before the first flush waits for rst_tb_done.
        start_req(OP_READ, 12'hfff, '0);
        repeat (8) @(negedge clk);
        run_flush("blocked");
        finish_req();
        check_rsp("blocked", OP_READ, 12'hfff, '0, 0, hit);

        for (int i = 0; i < 8; i++) begin
            access("read_miss", OP_READ, {llc_tag_t'(8'h10 + i), llc_set_t'(i)}, '0, 0, hit);
        end

        for (int i = 0; i < 8; i++) begin
            rand_addr = llc_addr_t'($urandom());
            data      = $urandom();
            access("write_read", OP_WRITE, rand_addr, data, 2, hit);
            access("write_read", OP_READ, rand_addr, '0, 1, hit);
        end

        // five tags in set 7 overflow the four ways.
        for (int i = 0; i < 5; i++) begin
            access("eviction", OP_WRITE, {llc_tag_t'(8'h20 + i), 4'h7}, $urandom(), 2, hit);
        end
        misses = 0;
        for (int i = 0; i < 5; i++) begin
            access("eviction", OP_READ, {llc_tag_t'(8'h20 + i), 4'h7}, '0, 2, hit);
            if (!hit) begin
                misses++;
            end
        end
        assert (misses >= 1) else begin
            $display("Error: eviction miss count expected at least 1 actual %0d", misses);
            stop_with_failure();
        end

        dirty_addr = 12'h5a3;
        access("flush", OP_WRITE, dirty_addr, $urandom(), 2, hit);
        mem_before = mem_model[dirty_addr];
        run_flush("flush");
        access("flush", OP_READ, dirty_addr, '0, 0, hit);
        // the sweep drops dirty lines without writing them back.
        compare_value("flush", "memory value", mem_before, mem_model[dirty_addr]);
        access("flush", OP_READ, dirty_addr, '0, 1, hit);

        for (int i = 0; i < 60; i++) begin
            rand_addr = {llc_tag_t'($urandom_range(7)), llc_set_t'($urandom_range(2))};
            if ($urandom_range(1) == 1) begin
                access("random", OP_WRITE, rand_addr, $urandom(), 2, hit);
            end else begin
                access("random", OP_READ, rand_addr, '0, 2, hit);
            end
        end

        repeat (4) @(posedge clk);
        if (dut_i.props_i.fail_count == 0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            stop_with_failure();
        end
    end

endmodule

// File: sources.f
+incdir+source
source/llc_pkg.sv
source/llc_input_decoder.sv
source/llc_localmem.sv
source/llc_process_request.sv
source/llc.sv
verification/llc_properties.sv
verification/llc_tb.sv
